/* imd_cfg_pkg.sv */
//////////////////////////////
// Configuration of the multiply/divide unit.
// Default register width of the core.
// Width helpers for the HI/LO pair and the iteration counters.
//////////////////////////////
`default_nettype none

package imd_cfg_pkg;

	// Register width of the core.
	// The top level takes it as the default of WIDTH.
	parameter int REG_WIDTH = 32;

	// The HI/LO pair holds two registers side by side.
	// HI sits in the upper half.
	function automatic int unsigned hilo_width(input int unsigned width);
		return 2 * width;
	endfunction

	// Width of a counter that runs from width down to zero.
	// Shared by the iterative multiplier and divider.
	function automatic int unsigned cnt_width(input int unsigned width);
		return $clog2(width + 1);
	endfunction

endpackage

`default_nettype wire

/* imd_op_pkg.sv */
//////////////////////////////
// Decoded operations of the multiply/divide unit.
// Operation code width and the operation enumeration.
//////////////////////////////
`default_nettype none

package imd_op_pkg;

	// Nine operations need four bits.
	parameter int IMDOP_WIDTH = 4;

	// Operation as handed over by the decode stage.
	typedef enum logic [IMDOP_WIDTH-1:0] {
		// No multiply/divide work.
		NOP  = 4'd0,
		// Move from HI to a register.
		MFHI = 4'd1,
		// Move from LO to a register.
		MFLO = 4'd2,
		// Move a register to HI.
		MTHI = 4'd3,
		// Move a register to LO.
		MTLO = 4'd4,
		// Signed multiply into HI/LO.
		MUL  = 4'd5,
		// Unsigned multiply into HI/LO.
		MULU = 4'd6,
		// Signed divide.
		// Remainder goes to HI and quotient to LO.
		DIV  = 4'd7,
		// Unsigned divide.
		DIVU = 4'd8
	} imd_op_t;

endpackage

`default_nettype wire

/* imd_long_mul.sv */
//////////////////////////////
// Iterative shift-add multiplier.
// Signed or unsigned, one bit per cycle, double-width product.
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module imd_long_mul #(
	parameter int WIDTH = imd_cfg_pkg::REG_WIDTH
) (
	input  logic                                         clk,
	input  logic                                         nrst,
	input  logic                                         i_start,
	input  logic                                         i_signd,
	input  logic [WIDTH-1:0]                             i_multiplicand,
	input  logic [WIDTH-1:0]                             i_multiplier,
	output logic                                         o_ready,
	output logic [imd_cfg_pkg::hilo_width(WIDTH)-1:0]    o_product
);

	localparam int CNT_W = imd_cfg_pkg::cnt_width(WIDTH);

	// Remaining shift-add steps.
	logic [CNT_W-1:0] cnt;
	// Multiplicand magnitude kept for the whole run.
	logic [WIDTH-1:0] mcand;
	// Result must be negated at the end.
	logic             neg;
	// Operand magnitudes at start.
	logic [WIDTH-1:0] mcand_mag;
	logic [WIDTH-1:0] mplier_mag;
	// Upper half plus the multiplicand, with carry.
	logic [WIDTH:0]   step_sum;

	// Two's complement magnitudes of signed operands.
	always_comb
	begin
		mcand_mag = i_multiplicand;
		mplier_mag = i_multiplier;
		if (i_signd && i_multiplicand[WIDTH-1])
			mcand_mag = -i_multiplicand;
		if (i_signd && i_multiplier[WIDTH-1])
			mplier_mag = -i_multiplier;
	end

	// Add the multiplicand when the current multiplier bit is set.
	assign step_sum = {1'b0, o_product[2*WIDTH-1:WIDTH]} +
		(o_product[0] ? {1'b0, mcand} : {(WIDTH+1){1'b0}});

	// Step counter and ready flag.
	// Ready drops on start and returns after WIDTH steps and the sign fix.
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			cnt <= '0;
			o_ready <= 1'b1;
		end
		else if (i_start)
		begin
			cnt <= CNT_W'(WIDTH);
			o_ready <= 1'b0;
		end
		else if (cnt != '0)
		begin
			cnt <= cnt - 1'b1;
		end
		else
		begin
			o_ready <= 1'b1;
		end
	end

	// Product register.
	// Low half starts as the multiplier and shifts out one bit per step.
	always_ff @(posedge clk)
	begin
		if (i_start)
		begin
			mcand <= mcand_mag;
			o_product <= {{WIDTH{1'b0}}, mplier_mag};
			neg <= i_signd && (i_multiplicand[WIDTH-1] ^ i_multiplier[WIDTH-1]);
		end
		else if (cnt != '0)
		begin
			o_product <= {step_sum, o_product[WIDTH-1:1]};
		end
		else if (!o_ready && neg)
		begin
			// Signs differed so the product is negative.
			o_product <= -o_product;
		end
	end

endmodule

`default_nettype wire

/* imd_long_div.sv */
//////////////////////////////
// Iterative restoring divider.
// Signed or unsigned with truncating MIPS sign rules.
// Result packs remainder high and quotient low.
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module imd_long_div #(
	parameter int WIDTH = imd_cfg_pkg::REG_WIDTH
) (
	input  logic                                         clk,
	input  logic                                         nrst,
	input  logic                                         i_start,
	input  logic                                         i_signd,
	input  logic [WIDTH-1:0]                             i_dividend,
	input  logic [WIDTH-1:0]                             i_divisor,
	output logic                                         o_ready,
	output logic [imd_cfg_pkg::hilo_width(WIDTH)-1:0]    o_remquot
);

	localparam int CNT_W = imd_cfg_pkg::cnt_width(WIDTH);

	// Remaining shift-subtract steps.
	logic [CNT_W-1:0] cnt;
	// Divisor magnitude.
	logic [WIDTH-1:0] dvs;
	// Partial remainder.
	logic [WIDTH-1:0] rem;
	// Dividend bits shift out at the top, quotient bits shift in below.
	logic [WIDTH-1:0] quo;
	// Sign corrections applied after the last step.
	logic             quo_neg;
	logic             rem_neg;
	// Operand magnitudes at start.
	logic [WIDTH-1:0] dvd_mag;
	logic [WIDTH-1:0] dvs_mag;
	// Shifted remainder and trial subtraction.
	logic [WIDTH:0]   trial;
	logic [WIDTH:0]   diff;

	// Magnitudes of signed operands.
	always_comb
	begin
		dvd_mag = i_dividend;
		dvs_mag = i_divisor;
		if (i_signd && i_dividend[WIDTH-1])
			dvd_mag = -i_dividend;
		if (i_signd && i_divisor[WIDTH-1])
			dvs_mag = -i_divisor;
	end

	// Bring down the next dividend bit and try the subtraction.
	// A set top bit of diff means the divisor did not fit.
	assign trial = {rem, quo[WIDTH-1]};
	assign diff = trial - {1'b0, dvs};

	// Step counter and ready flag.
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			cnt <= '0;
			o_ready <= 1'b1;
		end
		else if (i_start)
		begin
			cnt <= CNT_W'(WIDTH);
			o_ready <= 1'b0;
		end
		else if (cnt != '0)
		begin
			cnt <= cnt - 1'b1;
		end
		else
		begin
			o_ready <= 1'b1;
		end
	end

	// Remainder and quotient registers.
	always_ff @(posedge clk)
	begin
		if (i_start)
		begin
			rem <= '0;
			quo <= dvd_mag;
			dvs <= dvs_mag;
			quo_neg <= i_signd && (i_dividend[WIDTH-1] ^ i_divisor[WIDTH-1]);
			rem_neg <= i_signd && i_dividend[WIDTH-1];
		end
		else if (cnt != '0)
		begin
			if (!diff[WIDTH])
			begin
				// Divisor fits.
				rem <= diff[WIDTH-1:0];
				quo <= {quo[WIDTH-2:0], 1'b1};
			end
			else
			begin
				// Restore.
				rem <= trial[WIDTH-1:0];
				quo <= {quo[WIDTH-2:0], 1'b0};
			end
		end
		else if (!o_ready)
		begin
			// Quotient truncates toward zero.
			// Remainder follows the dividend sign.
			if (quo_neg)
				quo <= -quo;
			if (rem_neg)
				rem <= -rem;
		end
	end

	assign o_remquot = {rem, quo};

endmodule

`default_nettype wire

/* imd_hilo.sv */
//////////////////////////////
// HI/LO register pair.
// Memory-stage staging of move-to values and the writeback write.
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module imd_hilo #(
	parameter int WIDTH = imd_cfg_pkg::REG_WIDTH
) (
	input  logic                                         clk,
	input  logic                                         nrst,
	input  logic                                         i_advance,
	input  logic                                         i_nullify_mem,
	input  logic                                         i_nullify_wb,
	input  logic                                         i_mthi,
	input  logic                                         i_mtlo,
	input  logic [WIDTH-1:0]                             i_mt_val,
	input  logic                                         i_mul_done,
	input  logic [imd_cfg_pkg::hilo_width(WIDTH)-1:0]    i_mul_product,
	input  logic                                         i_div_done,
	input  logic [imd_cfg_pkg::hilo_width(WIDTH)-1:0]    i_div_remquot,
	output logic [imd_cfg_pkg::hilo_width(WIDTH)-1:0]    o_hilo
);

	// Move-to strobes and value held in the memory stage.
	logic             mem_mthi;
	logic             mem_mtlo;
	logic [WIDTH-1:0] mem_val;

	//////////////////////////////
	// Memory stage.
	//////////////////////////////

	// Strobes move on with the pipeline.
	// A memory-stage nullify drops them.
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			mem_mthi <= 1'b0;
			mem_mtlo <= 1'b0;
		end
		else if (i_advance)
		begin
			mem_mthi <= i_mthi && !i_nullify_mem;
			mem_mtlo <= i_mtlo && !i_nullify_mem;
		end
	end

	// Value follows the strobes.
	always_ff @(posedge clk)
	begin
		if (i_advance)
			mem_val <= i_mt_val;
	end

	//////////////////////////////
	// Writeback stage.
	//////////////////////////////

	// Long results win over a move-to landing in the same cycle.
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			o_hilo <= '0;
		end
		else if (i_mul_done)
		begin
			o_hilo <= i_mul_product;
		end
		else if (i_div_done)
		begin
			o_hilo <= i_div_remquot;
		end
		else if (i_advance && !i_nullify_wb)
		begin
			if (mem_mthi)
				o_hilo[2*WIDTH-1:WIDTH] <= mem_val;
			if (mem_mtlo)
				o_hilo[WIDTH-1:0] <= mem_val;
		end
	end

endmodule

`default_nettype wire

/* imd_ctrl.sv */
//////////////////////////////
// Execute-stage control of the multiply/divide unit.
// Decode, interlock stall, operand capture and start pulses.
// Move-from results and move-to strobes.
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module imd_ctrl #(
	parameter int WIDTH = imd_cfg_pkg::REG_WIDTH
) (
	input  logic                                         clk,
	input  logic                                         nrst,
	input  imd_op_pkg::imd_op_t                          i_op,
	input  logic [WIDTH-1:0]                             i_rs_val,
	input  logic [WIDTH-1:0]                             i_rt_val,
	input  logic                                         i_mem_stall,
	input  logic                                         i_fetch_stall,
	input  logic                                         i_nullify_execute,
	input  logic                                         i_mul_ready,
	input  logic                                         i_div_ready,
	input  logic [imd_cfg_pkg::hilo_width(WIDTH)-1:0]    i_hilo,
	output logic                                         o_exec_stall,
	output logic [WIDTH-1:0]                             o_rd_val,
	output logic                                         o_rd_valid,
	output logic [WIDTH-1:0]                             o_opa,
	output logic [WIDTH-1:0]                             o_opb,
	output logic                                         o_signd,
	output logic                                         o_mul_start,
	output logic                                         o_div_start,
	output logic                                         o_mthi,
	output logic                                         o_mtlo,
	output logic [WIDTH-1:0]                             o_mt_val,
	output logic                                         o_advance,
	output logic                                         o_mul_done,
	output logic                                         o_div_done
);

	// Decoded operation classes.
	logic is_mul;
	logic is_div;
	logic is_mf;
	logic is_mt;
	logic is_signed;
	// Operation needs HI/LO settled before it can go.
	logic interlock;
	// Long units running.
	logic mul_busy;
	logic div_busy;
	// Operation taken on this edge.
	logic accept;

	//////////////////////////////
	// Decode and stall.
	//////////////////////////////

	always_comb
	begin
		is_mul = (i_op == imd_op_pkg::MUL) || (i_op == imd_op_pkg::MULU);
		is_div = (i_op == imd_op_pkg::DIV) || (i_op == imd_op_pkg::DIVU);
		is_mf = (i_op == imd_op_pkg::MFHI) || (i_op == imd_op_pkg::MFLO);
		is_mt = (i_op == imd_op_pkg::MTHI) || (i_op == imd_op_pkg::MTLO);
		is_signed = (i_op == imd_op_pkg::MUL) || (i_op == imd_op_pkg::DIV);
		interlock = is_mf || is_mul || is_div;
	end

	// Own stall only when no outside stall holds the pipe.
	assign o_exec_stall = !i_mem_stall && !i_fetch_stall && (mul_busy || div_busy) && interlock;
	assign o_advance = !(o_exec_stall || i_mem_stall || i_fetch_stall);
	assign accept = o_advance && !i_nullify_execute;

	// Busy flag falls when ready is back and the start pulse is gone.
	// HI/LO takes the result on that same edge.
	assign o_mul_done = mul_busy && !o_mul_start && i_mul_ready;
	assign o_div_done = div_busy && !o_div_start && i_div_ready;

	//////////////////////////////
	// Long operation control.
	//////////////////////////////

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			mul_busy <= 1'b0;
			div_busy <= 1'b0;
			o_mul_start <= 1'b0;
			o_div_start <= 1'b0;
			o_signd <= 1'b0;
		end
		else
		begin
			// One-cycle pulses.
			o_mul_start <= accept && is_mul;
			o_div_start <= accept && is_div;
			if (accept && (is_mul || is_div))
				o_signd <= is_signed;
			if (accept && is_mul)
				mul_busy <= 1'b1;
			else if (o_mul_done)
				mul_busy <= 1'b0;
			if (accept && is_div)
				div_busy <= 1'b1;
			else if (o_div_done)
				div_busy <= 1'b0;
		end
	end

	// Operands for whichever long unit starts next.
	always_ff @(posedge clk)
	begin
		if (accept && (is_mul || is_div))
		begin
			o_opa <= i_rs_val;
			o_opb <= i_rt_val;
		end
		if (accept && is_mt)
			o_mt_val <= i_rs_val;
	end

	//////////////////////////////
	// Move-from and move-to.
	//////////////////////////////

	// Result valid lasts until the next advancing edge.
	// Strobes hand the move-to over to the memory stage.
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			o_rd_valid <= 1'b0;
			o_rd_val <= '0;
			o_mthi <= 1'b0;
			o_mtlo <= 1'b0;
		end
		else
		begin
			if (o_advance)
			begin
				o_rd_valid <= accept && is_mf;
				o_mthi <= accept && (i_op == imd_op_pkg::MTHI);
				o_mtlo <= accept && (i_op == imd_op_pkg::MTLO);
			end
			if (accept && is_mf)
			begin
				if (i_op == imd_op_pkg::MFHI)
					o_rd_val <= i_hilo[2*WIDTH-1:WIDTH];
				else
					o_rd_val <= i_hilo[WIDTH-1:0];
			end
		end
	end

endmodule

`default_nettype wire

/* imd_unit.sv */
//////////////////////////////
// Top level of the multiply/divide unit.
// Control, multiplier, divider and HI/LO pair.
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module imd_unit #(
	parameter int WIDTH = imd_cfg_pkg::REG_WIDTH
) (
	input  logic                   clk,
	input  logic                   nrst,
	input  imd_op_pkg::imd_op_t    i_op,
	input  logic [WIDTH-1:0]       i_rs_val,
	input  logic [WIDTH-1:0]       i_rt_val,
	input  logic                   i_mem_stall,
	input  logic                   i_fetch_stall,
	input  logic                   i_nullify_execute,
	input  logic                   i_nullify_mem,
	input  logic                   i_nullify_wb,
	output logic                   o_exec_stall,
	output logic [WIDTH-1:0]       o_rd_val,
	output logic                   o_rd_valid
);

	localparam int HW = imd_cfg_pkg::hilo_width(WIDTH);

	// Long unit operands and control.
	logic [WIDTH-1:0] opa;
	logic [WIDTH-1:0] opb;
	logic             signd;
	logic             mul_start;
	logic             div_start;
	logic             mul_ready;
	logic             div_ready;
	logic [HW-1:0]    mul_product;
	logic [HW-1:0]    div_remquot;
	// HI/LO path.
	logic             mthi;
	logic             mtlo;
	logic [WIDTH-1:0] mt_val;
	logic             advance;
	logic             mul_done;
	logic             div_done;
	logic [HW-1:0]    hilo;

	imd_ctrl #(
		.WIDTH (WIDTH)
	) u_ctrl (
		.clk               (clk),
		.nrst              (nrst),
		.i_op              (i_op),
		.i_rs_val          (i_rs_val),
		.i_rt_val          (i_rt_val),
		.i_mem_stall       (i_mem_stall),
		.i_fetch_stall     (i_fetch_stall),
		.i_nullify_execute (i_nullify_execute),
		.i_mul_ready       (mul_ready),
		.i_div_ready       (div_ready),
		.i_hilo            (hilo),
		.o_exec_stall      (o_exec_stall),
		.o_rd_val          (o_rd_val),
		.o_rd_valid        (o_rd_valid),
		.o_opa             (opa),
		.o_opb             (opb),
		.o_signd           (signd),
		.o_mul_start       (mul_start),
		.o_div_start       (div_start),
		.o_mthi            (mthi),
		.o_mtlo            (mtlo),
		.o_mt_val          (mt_val),
		.o_advance         (advance),
		.o_mul_done        (mul_done),
		.o_div_done        (div_done)
	);

	// Rs is the multiplicand and the dividend.
	imd_long_mul #(
		.WIDTH (WIDTH)
	) u_mul (
		.clk            (clk),
		.nrst           (nrst),
		.i_start        (mul_start),
		.i_signd        (signd),
		.i_multiplicand (opa),
		.i_multiplier   (opb),
		.o_ready        (mul_ready),
		.o_product      (mul_product)
	);

	imd_long_div #(
		.WIDTH (WIDTH)
	) u_div (
		.clk        (clk),
		.nrst       (nrst),
		.i_start    (div_start),
		.i_signd    (signd),
		.i_dividend (opa),
		.i_divisor  (opb),
		.o_ready    (div_ready),
		.o_remquot  (div_remquot)
	);

	imd_hilo #(
		.WIDTH (WIDTH)
	) u_hilo (
		.clk           (clk),
		.nrst          (nrst),
		.i_advance     (advance),
		.i_nullify_mem (i_nullify_mem),
		.i_nullify_wb  (i_nullify_wb),
		.i_mthi        (mthi),
		.i_mtlo        (mtlo),
		.i_mt_val      (mt_val),
		.i_mul_done    (mul_done),
		.i_mul_product (mul_product),
		.i_div_done    (div_done),
		.i_div_remquot (div_remquot),
		.o_hilo        (hilo)
	);

endmodule

`default_nettype wire

/* tb_clkgen.sv */
//////////////////////////////
// Testbench clock and reset generator.
// Free-running clock, active-low reset held for a number of cycles.
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
	parameter int HALF_PERIOD = 2,
	parameter int RST_CYCLES = 10
) (
	output logic o_clk,
	output logic o_nrst
);

	// 4 ns period with the default half period.
	initial
	begin
		o_clk = 1'b0;
		forever
			#(HALF_PERIOD) o_clk = ~o_clk;
	end

	// Release on a falling edge, away from the sampling edge.
	initial
	begin
		o_nrst = 1'b0;
		repeat (RST_CYCLES) @(posedge o_clk);
		@(negedge o_clk);
		o_nrst = 1'b1;
	end

endmodule

`default_nettype wire

/* tb_imd_unit.sv */
//////////////////////////////
// Table-driven testbench of the multiply/divide unit.
// Reference model of HI/LO and the move-to pipeline.
// LFSR operand rows, compare tasks and stall timeouts.
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_imd_unit;

	localparam int WIDTH = 32;
	localparam int STALL_LIMIT = 200;
	localparam int RESET_LIMIT = 100;
	// How a row's move-from result is checked.
	localparam logic [1:0] CHK_NONE = 2'd0;
	localparam logic [1:0] CHK_TAB = 2'd1;
	localparam logic [1:0] CHK_MODEL = 2'd2;

	// One stimulus row.
	// Nullify bits are {execute, mem, wb}.
	// Stall bits are {fetch, mem}.
	typedef struct packed {
		imd_op_pkg::imd_op_t op;
		logic [WIDTH-1:0]    rs;
		logic [WIDTH-1:0]    rt;
		logic [2:0]          nul;
		logic [1:0]          stl;
		logic                exp_stall;
		logic [1:0]          chk;
		logic [WIDTH-1:0]    exp_rd;
	} row_t;

	logic                clk;
	logic                nrst;
	imd_op_pkg::imd_op_t op;
	logic [WIDTH-1:0]    rs_val;
	logic [WIDTH-1:0]    rt_val;
	logic                mem_stall;
	logic                fetch_stall;
	logic                null_ex;
	logic                null_mem;
	logic                null_wb;
	logic                exec_stall;
	logic [WIDTH-1:0]    rd_val;
	logic                rd_valid;

	row_t        rows[$];
	int          cur_row;
	logic [31:0] lfsr;

	// Reference model state.
	logic [WIDTH-1:0] m_hi;
	logic [WIDTH-1:0] m_lo;
	logic [WIDTH-1:0] m_rd;
	logic             m_valid;
	// Move-to values in the execute and memory stages.
	logic             ex_hi;
	logic             ex_lo;
	logic [WIDTH-1:0] ex_val;
	logic             mem_hi;
	logic             mem_lo;
	logic [WIDTH-1:0] mem_val;

	tb_clkgen #(
		.HALF_PERIOD (2),
		.RST_CYCLES  (10)
	) u_clkgen (
		.o_clk  (clk),
		.o_nrst (nrst)
	);

	imd_unit #(
		.WIDTH (WIDTH)
	) uut (
		.clk               (clk),
		.nrst              (nrst),
		.i_op              (op),
		.i_rs_val          (rs_val),
		.i_rt_val          (rt_val),
		.i_mem_stall       (mem_stall),
		.i_fetch_stall     (fetch_stall),
		.i_nullify_execute (null_ex),
		.i_nullify_mem     (null_mem),
		.i_nullify_wb      (null_wb),
		.o_exec_stall      (exec_stall),
		.o_rd_val          (rd_val),
		.o_rd_valid        (rd_valid)
	);

	//////////////////////////////
	// Compare tasks.
	//////////////////////////////

	task automatic check_rd(input logic [WIDTH-1:0] got, input logic [WIDTH-1:0] exp);
		if (got !== exp)
		begin
			$display("Error: o_rd_val row %0d got %h expected %h", cur_row, got, exp);
			$display("Test FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_valid(input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("Error: o_rd_valid row %0d got %h expected %h", cur_row, got, exp);
			$display("Test FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_stall(input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("Error: o_exec_stall row %0d got %h expected %h", cur_row, got, exp);
			$display("Test FAILED");
			$fatal(1);
		end
	endtask

	//////////////////////////////
	// Random operands.
	//////////////////////////////

	// Galois LFSR with taps 32, 30, 26 and 25.
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'hA300_0000;
		return s >> 1;
	endfunction

	// One LFSR step per bit taken.
	task automatic rand_bits(input int n, output logic [WIDTH-1:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_next(lfsr);
			v = {v[WIDTH-2:0], lfsr[0]};
		end
	endtask

	//////////////////////////////
	// Reference model.
	//////////////////////////////

	// Full product or remainder high and quotient low.
	// 64-bit signed arithmetic truncates toward zero like DIV.
	function automatic logic [2*WIDTH-1:0] long_result(input imd_op_pkg::imd_op_t kind,
		input logic [WIDTH-1:0] a, input logic [WIDTH-1:0] b);
		logic signed [2*WIDTH-1:0] sa;
		logic signed [2*WIDTH-1:0] sb;
		logic signed [2*WIDTH-1:0] q;
		logic signed [2*WIDTH-1:0] r;
		if (kind == imd_op_pkg::MUL || kind == imd_op_pkg::DIV)
		begin
			sa = {{WIDTH{a[WIDTH-1]}}, a};
			sb = {{WIDTH{b[WIDTH-1]}}, b};
		end
		else
		begin
			sa = {{WIDTH{1'b0}}, a};
			sb = {{WIDTH{1'b0}}, b};
		end
		if (kind == imd_op_pkg::MUL || kind == imd_op_pkg::MULU)
			return sa * sb;
		q = sa / sb;
		r = sa % sb;
		return {r[WIDTH-1:0], q[WIDTH-1:0]};
	endfunction

	// One accepting edge of the row.
	// Move-from reads HI/LO before the writeback of the same edge.
	task automatic model_update(input row_t r);
		logic adv;
		logic acc;
		adv = !(r.stl[0] || r.stl[1]);
		acc = adv && !r.nul[2];
		if (!adv)
			return;
		m_valid = acc && (r.op == imd_op_pkg::MFHI || r.op == imd_op_pkg::MFLO);
		if (m_valid)
			m_rd = (r.op == imd_op_pkg::MFHI) ? m_hi : m_lo;
		// Writeback stage.
		if (mem_hi && !r.nul[0])
			m_hi = mem_val;
		if (mem_lo && !r.nul[0])
			m_lo = mem_val;
		// Memory stage.
		mem_hi = ex_hi && !r.nul[1];
		mem_lo = ex_lo && !r.nul[1];
		mem_val = ex_val;
		ex_hi = acc && (r.op == imd_op_pkg::MTHI);
		ex_lo = acc && (r.op == imd_op_pkg::MTLO);
		if (ex_hi || ex_lo)
			ex_val = r.rs;
		// Long results land before any later move-from can read them.
		if (acc && (r.op == imd_op_pkg::MUL || r.op == imd_op_pkg::MULU ||
			r.op == imd_op_pkg::DIV || r.op == imd_op_pkg::DIVU))
			{m_hi, m_lo} = long_result(r.op, r.rs, r.rt);
	endtask

	//////////////////////////////
	// Stimulus table.
	//////////////////////////////

	task automatic add_row(input imd_op_pkg::imd_op_t kind, input logic [WIDTH-1:0] a,
		input logic [WIDTH-1:0] b, input logic [2:0] nul, input logic [1:0] stl,
		input logic stall, input logic [1:0] chk, input logic [WIDTH-1:0] rd);
		row_t r;
		r.op = kind;
		r.rs = a;
		r.rt = b;
		r.nul = nul;
		r.stl = stl;
		r.exp_stall = stall;
		r.chk = chk;
		r.exp_rd = rd;
		rows.push_back(r);
	endtask

	task automatic build_table();
		logic [WIDTH-1:0]    sel;
		logic [WIDTH-1:0]    a;
		logic [WIDTH-1:0]    b;
		imd_op_pkg::imd_op_t kind;
		// Reset state.
		add_row(imd_op_pkg::NOP, 32'h0, 32'h0, 3'b000, 2'b00, 1'b0, CHK_NONE, 32'h0);
		add_row(imd_op_pkg::MFHI, 32'h0, 32'h0, 3'b000, 2'b00, 1'b0, CHK_TAB, 32'h0);
		add_row(imd_op_pkg::MFLO, 32'h0, 32'h0, 3'b000, 2'b00, 1'b0, CHK_TAB, 32'h0);
		// Move-to with two NOPs behind each.
		add_row(imd_op_pkg::MTHI, 32'h1234_5678, 32'h0, 3'b000, 2'b00, 1'b0, CHK_NONE, 32'h0);
		add_row(imd_op_pkg::NOP, 32'h0, 32'h0, 3'b000, 2'b00, 1'b0, CHK_NONE, 32'h0);
		add_row(imd_op_pkg::NOP, 32'h0, 32'h0, 3'b000, 2'b00, 1'b0, CHK_NONE, 32'h0);
		add_row(imd_op_pkg::MTLO, 32'h9abc_def0, 32'h0, 3'b000, 2'b00, 1'b0, CHK_NONE, 32'h0);
		add_row(imd_op_pkg::NOP, 32'h0, 32'h0, 3'b000, 2'b00, 1'b0, CHK_NONE, 32'h0);
		add_row(imd_op_pkg::NOP, 32'h0, 32'h0, 3'b000, 2'b00, 1'b0, CHK_NONE, 32'h0);
		add_row(imd_op_pkg::MFHI, 32'h0, 32'h0, 3'b000, 2'b00, 1'b0, CHK_TAB, 32'h1234_5678);
		add_row(imd_op_pkg::MFLO, 32'h0, 32'h0, 3'b000, 2'b00, 1'b0, CHK_TAB, 32'h9abc_def0);
		// Nullified in the memory stage and then in writeback.
		add_row(imd_op_pkg::MTHI, 32'hdead_beef, 32'h0, 3'b000, 2'b00, 1'b0, CHK_NONE, 32'h0);
		add_row(imd_op_pkg::NOP, 32'h0, 32'h0, 3'b010, 2'b00, 1'b0, CHK_NONE, 32'h0);
		add_row(imd_op_pkg::NOP, 32'h0, 32'h0, 3'b000, 2'b00, 1'b0, CHK_NONE, 32'h0);
		add_row(imd_op_pkg::MFHI, 32'h0, 32'h0, 3'b000, 2'b00, 1'b0, CHK_TAB, 32'h1234_5678);
		add_row(imd_op_pkg::MTLO, 32'h0bad_f00d, 32'h0, 3'b000, 2'b00, 1'b0, CHK_NONE, 32'h0);
		add_row(imd_op_pkg::NOP, 32'h0, 32'h0, 3'b000, 2'b00, 1'b0, CHK_NONE, 32'h0);
		add_row(imd_op_pkg::NOP, 32'h0, 32'h0, 3'b001, 2'b00, 1'b0, CHK_NONE, 32'h0);
		add_row(imd_op_pkg::MFLO, 32'h0, 32'h0, 3'b000, 2'b00, 1'b0, CHK_TAB, 32'h9abc_def0);
		// Fixed multiplies.
		add_row(imd_op_pkg::MULU, 32'h3, 32'h5, 3'b000, 2'b00, 1'b0, CHK_NONE, 32'h0);
		add_row(imd_op_pkg::MFHI, 32'h0, 32'h0, 3'b000, 2'b00, 1'b1, CHK_TAB, 32'h0);
		add_row(imd_op_pkg::MFLO, 32'h0, 32'h0, 3'b000, 2'b00, 1'b0, CHK_TAB, 32'hf);
		add_row(imd_op_pkg::MULU, 32'hffff_ffff, 32'hffff_ffff, 3'b000, 2'b00, 1'b0,
			CHK_NONE, 32'h0);
		add_row(imd_op_pkg::MFHI, 32'h0, 32'h0, 3'b000, 2'b00, 1'b1, CHK_TAB, 32'hffff_fffe);
		add_row(imd_op_pkg::MFLO, 32'h0, 32'h0, 3'b000, 2'b00, 1'b0, CHK_TAB, 32'h1);
		add_row(imd_op_pkg::MUL, 32'hffff_fffd, 32'h7, 3'b000, 2'b00, 1'b0, CHK_NONE, 32'h0);
		add_row(imd_op_pkg::MFHI, 32'h0, 32'h0, 3'b000, 2'b00, 1'b1, CHK_TAB, 32'hffff_ffff);
		add_row(imd_op_pkg::MFLO, 32'h0, 32'h0, 3'b000, 2'b00, 1'b0, CHK_TAB, 32'hffff_ffeb);
		add_row(imd_op_pkg::MUL, 32'h8000_0000, 32'h8000_0000, 3'b000, 2'b00, 1'b0,
			CHK_NONE, 32'h0);
		add_row(imd_op_pkg::MFHI, 32'h0, 32'h0, 3'b000, 2'b00, 1'b1, CHK_TAB, 32'h4000_0000);
		add_row(imd_op_pkg::MFLO, 32'h0, 32'h0, 3'b000, 2'b00, 1'b0, CHK_TAB, 32'h0);
		// Fixed divides with the remainder in HI.
		add_row(imd_op_pkg::DIVU, 32'd100, 32'd7, 3'b000, 2'b00, 1'b0, CHK_NONE, 32'h0);
		add_row(imd_op_pkg::MFHI, 32'h0, 32'h0, 3'b000, 2'b00, 1'b1, CHK_TAB, 32'd2);
		add_row(imd_op_pkg::MFLO, 32'h0, 32'h0, 3'b000, 2'b00, 1'b0, CHK_TAB, 32'd14);
		add_row(imd_op_pkg::DIV, 32'hffff_fff9, 32'h2, 3'b000, 2'b00, 1'b0, CHK_NONE, 32'h0);
		add_row(imd_op_pkg::MFHI, 32'h0, 32'h0, 3'b000, 2'b00, 1'b1, CHK_TAB, 32'hffff_ffff);
		add_row(imd_op_pkg::MFLO, 32'h0, 32'h0, 3'b000, 2'b00, 1'b0, CHK_TAB, 32'hffff_fffd);
		add_row(imd_op_pkg::DIV, 32'h7, 32'hffff_fffe, 3'b000, 2'b00, 1'b0, CHK_NONE, 32'h0);
		add_row(imd_op_pkg::MFHI, 32'h0, 32'h0, 3'b000, 2'b00, 1'b1, CHK_TAB, 32'h1);
		add_row(imd_op_pkg::MFLO, 32'h0, 32'h0, 3'b000, 2'b00, 1'b0, CHK_TAB, 32'hffff_fffd);
		// Interlock and then nullified operations in execute.
		add_row(imd_op_pkg::MUL, 32'd6, 32'd7, 3'b000, 2'b00, 1'b0, CHK_NONE, 32'h0);
		add_row(imd_op_pkg::MFLO, 32'h0, 32'h0, 3'b000, 2'b00, 1'b1, CHK_TAB, 32'd42);
		add_row(imd_op_pkg::MFHI, 32'h0, 32'h0, 3'b000, 2'b00, 1'b0, CHK_TAB, 32'h0);
		add_row(imd_op_pkg::MUL, 32'd9, 32'd9, 3'b100, 2'b00, 1'b0, CHK_NONE, 32'h0);
		add_row(imd_op_pkg::MFLO, 32'h0, 32'h0, 3'b000, 2'b00, 1'b0, CHK_TAB, 32'd42);
		add_row(imd_op_pkg::MFHI, 32'h0, 32'h0, 3'b100, 2'b00, 1'b0, CHK_NONE, 32'h0);
		// Outside stalls hold the result.
		add_row(imd_op_pkg::MFLO, 32'h0, 32'h0, 3'b000, 2'b00, 1'b0, CHK_TAB, 32'd42);
		add_row(imd_op_pkg::MFHI, 32'h0, 32'h0, 3'b000, 2'b01, 1'b0, CHK_MODEL, 32'h0);
		add_row(imd_op_pkg::MFHI, 32'h0, 32'h0, 3'b000, 2'b10, 1'b0, CHK_MODEL, 32'h0);
		add_row(imd_op_pkg::MFHI, 32'h0, 32'h0, 3'b000, 2'b00, 1'b0, CHK_TAB, 32'h0);
		add_row(imd_op_pkg::NOP, 32'h0, 32'h0, 3'b000, 2'b00, 1'b0, CHK_NONE, 32'h0);
		add_row(imd_op_pkg::MFLO, 32'h0, 32'h0, 3'b000, 2'b01, 1'b0, CHK_MODEL, 32'h0);
		// LFSR operands with results from the model.
		for (int i = 0; i < 8; i++)
		begin
			rand_bits(2, sel);
			rand_bits(WIDTH, a);
			rand_bits(WIDTH, b);
			case (sel[1:0])
				2'd0: kind = imd_op_pkg::MUL;
				2'd1: kind = imd_op_pkg::MULU;
				2'd2: kind = imd_op_pkg::DIV;
				default: kind = imd_op_pkg::DIVU;
			endcase
			// Division by zero is left out.
			if (b == '0)
				b = 32'h1;
			add_row(kind, a, b, 3'b000, 2'b00, 1'b0, CHK_NONE, 32'h0);
			add_row(imd_op_pkg::MFHI, 32'h0, 32'h0, 3'b000, 2'b00, 1'b1, CHK_MODEL, 32'h0);
			add_row(imd_op_pkg::MFLO, 32'h0, 32'h0, 3'b000, 2'b00, 1'b0, CHK_MODEL, 32'h0);
		end
	endtask

	//////////////////////////////
	// Run.
	//////////////////////////////

	// Hold the row until the interlock clears.
	task automatic wait_no_stall();
		int n;
		n = 0;
		while (exec_stall)
		begin
			if (n >= STALL_LIMIT)
			begin
				$display("Timed out in row %0d: o_exec_stall never cleared.", cur_row);
				$display("Test FAILED");
				$fatal(1);
			end
			n++;
			@(negedge clk);
			#1;
		end
	endtask

	initial
	begin
		row_t r;
		int   n;
		op = imd_op_pkg::NOP;
		rs_val = '0;
		rt_val = '0;
		mem_stall = 1'b0;
		fetch_stall = 1'b0;
		null_ex = 1'b0;
		null_mem = 1'b0;
		null_wb = 1'b0;
		{m_hi, m_lo, m_rd, m_valid} = '0;
		{ex_hi, ex_lo, ex_val, mem_hi, mem_lo, mem_val} = '0;
		cur_row = 0;
		lfsr = 32'h5299_f9b4;
		build_table();
		n = 0;
		// Reset may still be unknown at time zero.
		while (nrst !== 1'b1)
		begin
			if (n >= RESET_LIMIT)
			begin
				$display("Timed out waiting for reset to be released.");
				$display("Test FAILED");
				$fatal(1);
			end
			n++;
			@(posedge clk);
		end
		@(negedge clk);
		// Drive on the falling edge and check on the next one.
		foreach (rows[k])
		begin
			r = rows[k];
			cur_row = k;
			op = r.op;
			rs_val = r.rs;
			rt_val = r.rt;
			{null_ex, null_mem, null_wb} = r.nul;
			{fetch_stall, mem_stall} = r.stl;
			#1;
			check_stall(exec_stall, r.exp_stall);
			wait_no_stall();
			@(negedge clk);
			model_update(r);
			check_valid(rd_valid, m_valid);
			if (r.chk == CHK_TAB)
				check_rd(rd_val, r.exp_rd);
			else if (r.chk == CHK_MODEL)
				check_rd(rd_val, m_rd);
		end
		$display("Test OK");
		$finish;
	end

endmodule

`default_nettype wire

/* imd_unit.f */
imd_cfg_pkg.sv
imd_op_pkg.sv
imd_long_mul.sv
imd_long_div.sv
imd_hilo.sv
imd_ctrl.sv
imd_unit.sv
tb_clkgen.sv
tb_imd_unit.sv

/* Bender.yml */
package:
  name: imd_unit

sources:
  - imd_cfg_pkg.sv
  - imd_op_pkg.sv
  - imd_long_mul.sv
  - imd_long_div.sv
  - imd_hilo.sv
  - imd_ctrl.sv
  - imd_unit.sv
  - target: test
    files:
      - tb_clkgen.sv
      - tb_imd_unit.sv
